// ==== hdl/axi4LitePkg.sv ====
package axi4LitePkg;

  // bus geometry shared by the engines, the slave and the testbench.
  localparam int DataWidth = 32;
  localparam int StrbWidth = DataWidth / 8;
  localparam int AddrWidth = 12;

  // only the two codes this slave can return.
  typedef enum logic [1:0] {
    RespOkay   = 2'd0,
    RespSlvErr = 2'd2
  } respT;

  // one address beat, shared by AW and AR.
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
  } addrChanT;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb; // one bit per byte lane, bit 0 is the lowest byte.
  } wrDataChanT;

  typedef struct packed {
    respT resp;
  } wrRespChanT;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    respT                 resp;
  } rdDataChanT;

endpackage

// ==== hdl/axi4LiteChanCapture.sv ====
`timescale 1ns/1ps

module axi4LiteChanCapture #(
  parameter type payloadT = logic
) (
  input  logic    aclk,
  input  logic    rst,
  input  logic    inValid,
  output logic    inReady,
  input  payloadT inPayload,
  output logic    full,
  input  logic    take,
  output payloadT payload
);

  // a single slot, so the stage only listens while it is empty.
  assign inReady = !full;

  always_ff @(posedge aclk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (take) begin
      full <= 1'b0;
    end else if (inValid && inReady) begin
      full <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (inValid && inReady) payload <= inPayload;
  end

  // the consumer may only release a beat that it was shown.
  takeWhenFullCheck: assert property (@(posedge aclk) disable iff (rst)
    take |-> full);

endmodule

// ==== hdl/axi4LiteWriteMaster.sv ====
`timescale 1ns/1ps

module axi4LiteWriteMaster
  import axi4LitePkg::*;
(
  input  logic       aclk,
  input  logic       rst,
  input  logic       wrStart,
  input  addrChanT   wrAddr,
  input  wrDataChanT wrData,
  output logic       wrBusy,
  output logic       wrDone,
  output respT       wrResp,
  output logic       awValid,
  input  logic       awReady,
  output addrChanT   awPayload,
  output logic       wValid,
  input  logic       wReady,
  output wrDataChanT wPayload,
  input  logic       bValid,
  output logic       bReady,
  input  wrRespChanT bPayload
);

  typedef enum logic [1:0] {
    Idle,
    Req,
    WaitB
  } stateT;

  stateT state;
  logic  accept;
  logic  awPending;
  logic  wPending;

  assign accept    = (state == Idle) && wrStart; // starts while busy fall through here.
  assign awPending = awValid && !awReady;
  assign wPending  = wValid && !wReady;
  assign wrBusy    = (state != Idle);
  assign bReady    = (state == WaitB);

  always_ff @(posedge aclk) begin
    if (rst) begin
      state   <= Idle;
      awValid <= 1'b0;
      wValid  <= 1'b0;
      wrDone  <= 1'b0;
    end else begin
      wrDone <= 1'b0;
      case (state)
        Idle: begin
          if (accept) begin
            awValid <= 1'b1;
            wValid  <= 1'b1;
            state   <= Req;
          end
        end
        Req: begin
          // each beat drops on its own handshake, so AW and W may finish in either order.
          if (awReady) awValid <= 1'b0;
          if (wReady) wValid <= 1'b0;
          if (!awPending && !wPending) state <= WaitB;
        end
        WaitB: begin
          if (bValid && bReady) begin
            wrDone <= 1'b1;
            state  <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      awPayload <= wrAddr;
      wPayload  <= wrData;
    end
    if (bValid && bReady) wrResp <= bPayload.resp; // held for the done cycle.
  end

  awHoldCheck: assert property (@(posedge aclk) disable iff (rst)
    awValid && !awReady |=> awValid && $stable(awPayload));

  wHoldCheck: assert property (@(posedge aclk) disable iff (rst)
    wValid && !wReady |=> wValid && $stable(wPayload));

endmodule

// ==== hdl/axi4LiteReadMaster.sv ====
`timescale 1ns/1ps

module axi4LiteReadMaster
  import axi4LitePkg::*;
(
  input  logic       aclk,
  input  logic       rst,
  input  logic       rdStart,
  input  addrChanT   rdAddr,
  output logic       rdBusy,
  output logic       rdDone,
  output rdDataChanT rdResult,
  output logic       arValid,
  input  logic       arReady,
  output addrChanT   arPayload,
  input  logic       rValid,
  output logic       rReady,
  input  rdDataChanT rPayload
);

  typedef enum logic [1:0] {
    Idle,
    Req,
    WaitR
  } stateT;

  stateT state;
  logic  accept;

  assign accept = (state == Idle) && rdStart;
  assign rdBusy = (state != Idle);
  assign rReady = (state == WaitR);

  always_ff @(posedge aclk) begin
    if (rst) begin
      state   <= Idle;
      arValid <= 1'b0;
      rdDone  <= 1'b0;
    end else begin
      rdDone <= 1'b0;
      case (state)
        Idle: begin
          if (accept) begin
            arValid <= 1'b1;
            state   <= Req;
          end
        end
        Req: begin
          if (arReady) begin
            arValid <= 1'b0;
            state   <= WaitR;
          end
        end
        WaitR: begin
          if (rValid && rReady) begin
            rdDone <= 1'b1;
            state  <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) arPayload <= rdAddr;
    if (rValid && rReady) rdResult <= rPayload; // data and response together.
  end

  arHoldCheck: assert property (@(posedge aclk) disable iff (rst)
    arValid && !arReady |=> arValid && $stable(arPayload));

endmodule

// ==== hdl/axi4LiteRegSlave.sv ====
`timescale 1ns/1ps

module axi4LiteRegSlave
  import axi4LitePkg::*;
#(
  parameter int NumRegs = 16
) (
  input  logic       aclk,
  input  logic       rst,
  input  logic       awValid,
  output logic       awReady,
  input  addrChanT   awPayload,
  input  logic       wValid,
  output logic       wReady,
  input  wrDataChanT wPayload,
  output logic       bValid,
  input  logic       bReady,
  output wrRespChanT bPayload,
  input  logic       arValid,
  output logic       arReady,
  input  addrChanT   arPayload,
  output logic       rValid,
  input  logic       rReady,
  output rdDataChanT rPayload
);

  // word index width; a bank of one register still gets a one-bit index.
  localparam int IdxWidth = (NumRegs > 1) ? $clog2(NumRegs) : 1;

  logic [DataWidth-1:0] regs [NumRegs];

  logic       awFull;
  logic       wFull;
  logic       arFull;
  addrChanT   awHeld;
  wrDataChanT wHeld;
  addrChanT   arHeld;
  logic       wrTake;
  logic       rdTake;
  logic       wrGo;
  logic       rdGo;
  logic       awInRange;
  logic       arInRange;

  logic [IdxWidth-1:0] awIdx;
  logic [IdxWidth-1:0] arIdx;

  axi4LiteChanCapture #(.payloadT(addrChanT)) awCapture (
    .aclk(aclk), .rst(rst),
    .inValid(awValid), .inReady(awReady), .inPayload(awPayload),
    .full(awFull), .take(wrTake), .payload(awHeld)
  );

  axi4LiteChanCapture #(.payloadT(wrDataChanT)) wCapture (
    .aclk(aclk), .rst(rst),
    .inValid(wValid), .inReady(wReady), .inPayload(wPayload),
    .full(wFull), .take(wrTake), .payload(wHeld)
  );

  axi4LiteChanCapture #(.payloadT(addrChanT)) arCapture (
    .aclk(aclk), .rst(rst),
    .inValid(arValid), .inReady(arReady), .inPayload(arPayload),
    .full(arFull), .take(rdTake), .payload(arHeld)
  );

  // captures are released only when the response is accepted.
  assign wrTake = bValid && bReady;
  assign rdTake = rValid && rReady;
  assign wrGo   = awFull && wFull && !bValid;
  assign rdGo   = arFull && !rValid;

  assign awInRange = (awHeld.addr < NumRegs * 4);
  assign arInRange = (arHeld.addr < NumRegs * 4);
  assign awIdx     = awHeld.addr[IdxWidth+1:2]; // low two bits select a byte and are ignored.
  assign arIdx     = arHeld.addr[IdxWidth+1:2];

  always_ff @(posedge aclk) begin
    if (rst) begin
      for (int i = 0; i < NumRegs; i++) regs[i] <= '0;
    end else if (wrGo && awInRange) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (wHeld.strb[b]) regs[awIdx][8*b +: 8] <= wHeld.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      bValid <= 1'b0;
      rValid <= 1'b0;
    end else begin
      if (wrTake) bValid <= 1'b0;
      else if (wrGo) bValid <= 1'b1;
      if (rdTake) rValid <= 1'b0;
      else if (rdGo) rValid <= 1'b1;
    end
  end

  // a read in the same cycle as a write sees the old register value.
  always_ff @(posedge aclk) begin
    if (wrGo) bPayload.resp <= awInRange ? RespOkay : RespSlvErr;
    if (rdGo) begin
      rPayload.data <= arInRange ? regs[arIdx] : '0;
      rPayload.resp <= arInRange ? RespOkay : RespSlvErr;
    end
  end

  bHoldCheck: assert property (@(posedge aclk) disable iff (rst)
    bValid && !bReady |=> bValid && $stable(bPayload));

  rHoldCheck: assert property (@(posedge aclk) disable iff (rst)
    rValid && !rReady |=> rValid && $stable(rPayload));

endmodule

// ==== hdl/axi4LiteSubsystemTop.sv ====
`timescale 1ns/1ps

module axi4LiteSubsystemTop
  import axi4LitePkg::*;
#(
  parameter int NumRegs = 16
) (
  input  logic       aclk,
  input  logic       rst,
  input  logic       wrStart,
  input  addrChanT   wrAddr,
  input  wrDataChanT wrData,
  output logic       wrBusy,
  output logic       wrDone,
  output respT       wrResp,
  input  logic       rdStart,
  input  addrChanT   rdAddr,
  output logic       rdBusy,
  output logic       rdDone,
  output rdDataChanT rdResult
);

  logic       awValid;
  logic       awReady;
  addrChanT   awPayload;
  logic       wValid;
  logic       wReady;
  wrDataChanT wPayload;
  logic       bValid;
  logic       bReady;
  wrRespChanT bPayload;
  logic       arValid;
  logic       arReady;
  addrChanT   arPayload;
  logic       rValid;
  logic       rReady;
  rdDataChanT rPayload;

  axi4LiteWriteMaster writeMaster (
    .aclk(aclk), .rst(rst),
    .wrStart(wrStart), .wrAddr(wrAddr), .wrData(wrData),
    .wrBusy(wrBusy), .wrDone(wrDone), .wrResp(wrResp),
    .awValid(awValid), .awReady(awReady), .awPayload(awPayload),
    .wValid(wValid), .wReady(wReady), .wPayload(wPayload),
    .bValid(bValid), .bReady(bReady), .bPayload(bPayload)
  );

  axi4LiteReadMaster readMaster (
    .aclk(aclk), .rst(rst),
    .rdStart(rdStart), .rdAddr(rdAddr),
    .rdBusy(rdBusy), .rdDone(rdDone), .rdResult(rdResult),
    .arValid(arValid), .arReady(arReady), .arPayload(arPayload),
    .rValid(rValid), .rReady(rReady), .rPayload(rPayload)
  );

  axi4LiteRegSlave #(.NumRegs(NumRegs)) regSlave (
    .aclk(aclk), .rst(rst),
    .awValid(awValid), .awReady(awReady), .awPayload(awPayload),
    .wValid(wValid), .wReady(wReady), .wPayload(wPayload),
    .bValid(bValid), .bReady(bReady), .bPayload(bPayload),
    .arValid(arValid), .arReady(arReady), .arPayload(arPayload),
    .rValid(rValid), .rReady(rReady), .rPayload(rPayload)
  );

endmodule

// ==== verification/axi4LiteSubsystemTb.sv ====
`timescale 1ns/1ps

module axi4LiteSubsystemTb
  import axi4LitePkg::*;
();

  localparam int TimeoutCycles = 50;
  localparam int QuietCycles   = 6;

  logic       aclk;
  logic       rst;
  logic       wrStart;
  addrChanT   wrAddr;
  wrDataChanT wrData;
  logic       wrBusy;
  logic       wrDone;
  respT       wrResp;
  logic       rdStart;
  addrChanT   rdAddr;
  logic       rdBusy;
  logic       rdDone;
  rdDataChanT rdResult;

  logic [15:0]          lfsrState;
  int                   numRegs;
  logic [DataWidth-1:0] model [];

  axi4LiteSubsystemTop dut0 (
    .aclk(aclk), .rst(rst),
    .wrStart(wrStart), .wrAddr(wrAddr), .wrData(wrData),
    .wrBusy(wrBusy), .wrDone(wrDone), .wrResp(wrResp),
    .rdStart(rdStart), .rdAddr(rdAddr),
    .rdBusy(rdBusy), .rdDone(rdDone), .rdResult(rdResult)
  );

  initial aclk = 1'b0;
  always #20 aclk = ~aclk;

  // x^16 + x^14 + x^13 + x^11, shifted toward the top bit.
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits      = {bits[30:0], lfsrState[15]};
      lfsrState = lfsrNext(lfsrState); // one step per bit taken.
    end
    return bits;
  endfunction

  function automatic logic inRange(input logic [AddrWidth-1:0] addr);
    return addr < numRegs * 4;
  endfunction

  function automatic respT writeRespFor(input logic [AddrWidth-1:0] addr);
    if (inRange(addr)) return RespOkay;
    return RespSlvErr;
  endfunction

  function automatic rdDataChanT readResultFor(input logic [AddrWidth-1:0] addr);
    rdDataChanT r;
    r.data = '0;
    r.resp = RespSlvErr;
    if (inRange(addr)) begin
      r.data = model[addr >> 2];
      r.resp = RespOkay;
    end
    return r;
  endfunction

  // out of range writes leave the bank alone.
  function automatic void applyWrite(input logic [AddrWidth-1:0] addr,
                                     input logic [DataWidth-1:0] data,
                                     input logic [StrbWidth-1:0] strb);
    if (inRange(addr)) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (strb[b]) model[addr >> 2][8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  task automatic stopOnFailure(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopping at the first error.");
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (exp !== act)
      stopOnFailure($sformatf("[ERROR] %0d ns: %s expected %b got %b", $time, name, exp, act));
  endtask

  task automatic checkResp(input string name, input respT exp, input respT act);
    if (exp !== act)
      stopOnFailure($sformatf("[ERROR] %0d ns: %s expected %0d got %0d",
                              $time, name, exp, act));
  endtask

  task automatic checkRead(input string name, input rdDataChanT exp, input rdDataChanT act);
    if (exp !== act)
      stopOnFailure($sformatf("[ERROR] %0d ns: %s expected data %h resp %0d got data %h resp %0d",
                              $time, name, exp.data, exp.resp, act.data, act.resp));
  endtask

  // every command task is entered and left on a falling edge.
  task automatic doWrite(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                         input logic [StrbWidth-1:0] strb);
    respT expResp;
    int   cycles;
    expResp     = writeRespFor(addr);
    wrStart     = 1'b1;
    wrAddr.addr = addr;
    wrData.data = data;
    wrData.strb = strb;
    @(negedge aclk);
    wrStart = 1'b0;
    cycles  = 0;
    while (!wrDone) begin
      @(negedge aclk);
      cycles++;
      if (cycles > TimeoutCycles) stopOnFailure("timeout: wrDone never came after a write start");
    end
    checkResp("wrResp", expResp, wrResp);
    applyWrite(addr, data, strb);
  endtask

  task automatic doRead(input logic [AddrWidth-1:0] addr);
    rdDataChanT expected;
    int         cycles;
    expected    = readResultFor(addr);
    rdStart     = 1'b1;
    rdAddr.addr = addr;
    @(negedge aclk);
    rdStart = 1'b0;
    cycles  = 0;
    while (!rdDone) begin
      @(negedge aclk);
      cycles++;
      if (cycles > TimeoutCycles) stopOnFailure("timeout: rdDone never came after a read start");
    end
    checkRead("rdResult", expected, rdResult);
  endtask

  // the read expects the bank as it stood before this write.
  task automatic doBoth(input logic [AddrWidth-1:0] wAddr, input logic [DataWidth-1:0] data,
                        input logic [StrbWidth-1:0] strb, input logic [AddrWidth-1:0] rAddr);
    respT       expResp;
    rdDataChanT expected;
    logic       wrSeen;
    logic       rdSeen;
    int         cycles;
    expResp     = writeRespFor(wAddr);
    expected    = readResultFor(rAddr);
    wrStart     = 1'b1;
    rdStart     = 1'b1;
    wrAddr.addr = wAddr;
    wrData.data = data;
    wrData.strb = strb;
    rdAddr.addr = rAddr;
    @(negedge aclk);
    wrStart = 1'b0;
    rdStart = 1'b0;
    wrSeen  = 1'b0;
    rdSeen  = 1'b0;
    cycles  = 0;
    while (!(wrSeen && rdSeen)) begin
      if (wrDone && !wrSeen) begin
        wrSeen = 1'b1;
        checkResp("wrResp", expResp, wrResp);
      end
      if (rdDone && !rdSeen) begin
        rdSeen = 1'b1;
        checkRead("rdResult", expected, rdResult);
      end
      if (!(wrSeen && rdSeen)) begin
        @(negedge aclk);
        cycles++;
        if (cycles > TimeoutCycles && !wrSeen)
          stopOnFailure("timeout: wrDone never came during a joint write and read");
        if (cycles > TimeoutCycles && !rdSeen)
          stopOnFailure("timeout: rdDone never came during a joint write and read");
      end
    end
    applyWrite(wAddr, data, strb);
  endtask

  task automatic readAll();
    for (int i = 0; i < numRegs; i++) doRead(i * 4);
  endtask

  // a second start lands while the write engine is busy and must be dropped.
  task automatic writeWhileBusy(input logic [AddrWidth-1:0] addr,
                                input logic [AddrWidth-1:0] ignoredAddr);
    logic [DataWidth-1:0] data;
    logic                 pulsed;
    int                   cycles;
    data        = takeBits(32);
    wrStart     = 1'b1;
    wrAddr.addr = addr;
    wrData.data = data;
    wrData.strb = 4'hF;
    @(negedge aclk);
    wrStart = 1'b0;
    pulsed  = 1'b0;
    cycles  = 0;
    while (!wrDone) begin
      if (!pulsed && wrBusy) begin
        wrStart     = 1'b1;
        wrAddr.addr = ignoredAddr;
        wrData.data = ~data;
        pulsed      = 1'b1;
      end else begin
        wrStart = 1'b0;
      end
      @(negedge aclk);
      cycles++;
      if (cycles > TimeoutCycles) stopOnFailure("timeout: wrDone never came after a write start");
    end
    wrStart = 1'b0;
    if (!pulsed) stopOnFailure("the write engine never showed busy, so no extra start was sent");
    checkResp("wrResp", writeRespFor(addr), wrResp);
    applyWrite(addr, data, 4'hF);
    for (int i = 0; i < QuietCycles; i++) begin
      @(negedge aclk);
      checkFlag("wrDone", 1'b0, wrDone);
      checkFlag("wrBusy", 1'b0, wrBusy);
    end
    doRead(ignoredAddr);
    doRead(addr);
  endtask

  task automatic readWhileBusy(input logic [AddrWidth-1:0] addr,
                               input logic [AddrWidth-1:0] ignoredAddr);
    rdDataChanT expected;
    logic       pulsed;
    int         cycles;
    expected    = readResultFor(addr);
    rdStart     = 1'b1;
    rdAddr.addr = addr;
    @(negedge aclk);
    rdStart = 1'b0;
    pulsed  = 1'b0;
    cycles  = 0;
    while (!rdDone) begin
      if (!pulsed && rdBusy) begin
        rdStart     = 1'b1;
        rdAddr.addr = ignoredAddr;
        pulsed      = 1'b1;
      end else begin
        rdStart = 1'b0;
      end
      @(negedge aclk);
      cycles++;
      if (cycles > TimeoutCycles) stopOnFailure("timeout: rdDone never came after a read start");
    end
    rdStart = 1'b0;
    if (!pulsed) stopOnFailure("the read engine never showed busy, so no extra start was sent");
    checkRead("rdResult", expected, rdResult);
    for (int i = 0; i < QuietCycles; i++) begin
      @(negedge aclk);
      checkFlag("rdDone", 1'b0, rdDone);
      checkFlag("rdBusy", 1'b0, rdBusy);
    end
  endtask

  task automatic checkResetState();
    checkFlag("wrBusy", 1'b0, wrBusy);
    checkFlag("rdBusy", 1'b0, rdBusy);
    readAll();
  endtask

  task automatic fullWordWrites();
    for (int i = 0; i < numRegs; i++) doWrite(i * 4, takeBits(32), 4'hF);
    readAll();
  endtask

  task automatic partialStrobeWrites();
    logic [AddrWidth-1:0] addr;
    for (int k = 0; k < 24; k++) begin
      addr = (takeBits(4) % numRegs) * 4 + takeBits(2); // low bits must not matter.
      doWrite(addr, takeBits(32), takeBits(4));
      doRead(addr);
    end
    readAll();
  endtask

  task automatic outOfRangeAccess();
    doWrite(numRegs * 4, takeBits(32), 4'hF);
    doWrite(12'h123, takeBits(32), 4'hF);
    doWrite(12'hFFC, takeBits(32), takeBits(4));
    readAll();
    doRead(numRegs * 4);
    doRead(12'hA00);
  endtask

  task automatic concurrentAccess();
    logic [AddrWidth-1:0] wIdx;
    logic [AddrWidth-1:0] rIdx;
    for (int k = 0; k < 6; k++) begin
      wIdx = takeBits(4) % numRegs;
      rIdx = (wIdx + 1 + takeBits(3)) % numRegs; // never the written word.
      doBoth(wIdx * 4, takeBits(32), takeBits(4), rIdx * 4);
    end
    doBoth(12'h014, takeBits(32), 4'hF, 12'h014);
    writeWhileBusy(12'h008, 12'h030);
    readWhileBusy(12'h00C, 12'h100);
    readAll();
  endtask

  initial begin
    lfsrState = 16'd76;
    numRegs   = dut0.NumRegs;
    model     = new[numRegs];
    foreach (model[i]) model[i] = '0;
    rst     = 1'b1;
    wrStart = 1'b0;
    wrAddr  = '0;
    wrData  = '0;
    rdStart = 1'b0;
    rdAddr  = '0;
    repeat (2) @(negedge aclk);
    rst = 1'b0;
    checkResetState();
    fullWordWrites();
    partialStrobeWrites();
    outOfRangeAccess();
    concurrentAccess();
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/axi4LitePkg.sv
hdl/axi4LiteChanCapture.sv
hdl/axi4LiteWriteMaster.sv
hdl/axi4LiteReadMaster.sv
hdl/axi4LiteRegSlave.sv
hdl/axi4LiteSubsystemTop.sv
verification/axi4LiteSubsystemTb.sv

// ==== Bender.yml ====
package:
  name: axi4_lite_subsystem

dependencies: {}

sources:
  - files:
      - hdl/axi4LitePkg.sv
      - hdl/axi4LiteChanCapture.sv
      - hdl/axi4LiteWriteMaster.sv
      - hdl/axi4LiteReadMaster.sv
      - hdl/axi4LiteRegSlave.sv
      - hdl/axi4LiteSubsystemTop.sv

  - target: test
    files:
      - verification/axi4LiteSubsystemTb.sv
